/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dw_conv
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/dw_cfg_pkg.sv */
package dw_cfg_pkg;

    localparam int CH_NUM      = 4;                         // channels per pixel vector
    localparam int DATA_W      = 8;                         // signed pixel and weight width
    localparam int ACC_W       = 20;                        // signed sum width per channel
    localparam int MAX_LINE    = 64;                        // line memory depth
    localparam int LINE_AW     = $clog2(MAX_LINE);          // line address width

    // a line length of 0 on cfg_line_len selects MAX_LINE
    localparam int OUT_CREDITS = 4;                         // downstream buffer depth
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);   // outstanding counter width
    localparam int PIPE_LAT    = 4;                         // input to output cycles

    localparam int TAP_NUM     = 9;                         // 3x3 taps per channel
    localparam int TAP_AW      = 4;                         // tap index width
    localparam int CH_AW       = $clog2(CH_NUM);            // channel index width

endpackage

/* logic/dw_conv_pe.sv */
`timescale 1ns/1ps

module dw_conv_pe
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   wt_we,
    input  wt_wr_t wt_wr,
    input  logic   win_valid,
    input  win_t   win,
    output logic   res_valid,
    output res_t   res
);

    logic signed [DATA_W-1:0]   wt_q   [CH_NUM][TAP_NUM];
    logic signed [2*DATA_W-1:0] prod_q [CH_NUM][TAP_NUM];
    logic signed [ACC_W-1:0]    sum_d  [CH_NUM];
    pix_vec_t                   tap_pix [TAP_NUM];
    logic                       prod_valid;
    logic                       prod_ok;

    // tap = 3*row + col
    assign tap_pix[0] = win.c0.top;
    assign tap_pix[1] = win.c1.top;
    assign tap_pix[2] = win.c2.top;
    assign tap_pix[3] = win.c0.mid;
    assign tap_pix[4] = win.c1.mid;
    assign tap_pix[5] = win.c2.mid;
    assign tap_pix[6] = win.c0.bot;
    assign tap_pix[7] = win.c1.bot;
    assign tap_pix[8] = win.c2.bot;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int t = 0; t < TAP_NUM; t++) begin
                    wt_q[c][t] <= '0;
                end
            end
        end else if (wt_we && (wt_wr.tap < TAP_AW'(TAP_NUM))) begin
            wt_q[wt_wr.ch][wt_wr.tap] <= wt_wr.wt;  // used from the next beat on
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_valid <= 1'b0;
            prod_ok    <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            prod_ok    <= win.win_ok;
            res_valid  <= prod_valid;
        end
    end

    // stage 1: products
    always_ff @(posedge clk) begin
        for (int c = 0; c < CH_NUM; c++) begin
            for (int t = 0; t < TAP_NUM; t++) begin
                prod_q[c][t] <= $signed(tap_pix[t].px[c]) * wt_q[c][t];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            sum_d[c] = '0;
            for (int t = 0; t < TAP_NUM; t++) begin
                sum_d[c] = sum_d[c] + ACC_W'(prod_q[c][t]);   // sign extended
            end
        end
    end

    // stage 2: per-channel sums
    always_ff @(posedge clk) begin
        for (int c = 0; c < CH_NUM; c++) begin
            res.sum[c] <= sum_d[c];
        end
        res.win_ok <= prod_ok;
    end

    a_wt_tap: assert property (
        @(posedge clk) disable iff (!rstn) wt_we |-> (wt_wr.tap < TAP_AW'(TAP_NUM))
    ) else $error("weight write to tap %0d", wt_wr.tap);

endmodule

/* logic/dw_conv_top.sv */
`timescale 1ns/1ps

module dw_conv_top
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  pix_vec_t           in_pix,
    output logic               in_credit,
    output logic               out_valid,
    output res_t               out_res,
    input  logic               out_credit,
    input  logic               cfg_apply,
    input  logic [LINE_AW-1:0] cfg_line_len,
    input  logic               wt_we,
    input  wt_wr_t             wt_wr
);

    logic                 col_valid;
    row_col_t             col;
    logic                 win_valid;
    win_t                 win;
    logic [OUT_CNT_W-1:0] outstanding;     // beats accepted, not yet credited back

    dw_row_buff u_row_buff (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .in_pix       (in_pix),
        .cfg_apply    (cfg_apply),
        .cfg_line_len (cfg_line_len),
        .col_valid    (col_valid),
        .col          (col)
    );

    dw_window u_window (
        .clk          (clk),
        .rstn         (rstn),
        .cfg_apply    (cfg_apply),
        .cfg_line_len (cfg_line_len),
        .col_valid    (col_valid),
        .col          (col),
        .win_valid    (win_valid),
        .win          (win)
    );

    dw_conv_pe u_pe (
        .clk       (clk),
        .rstn      (rstn),
        .wt_we     (wt_we),
        .wt_wr     (wt_wr),
        .win_valid (win_valid),
        .win       (win),
        .res_valid (out_valid),
        .res       (out_res)
    );

    // one input credit back per output credit, one cycle later
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_credit   <= 1'b0;
            outstanding <= '0;
        end else begin
            in_credit <= out_credit;
            case ({in_valid, out_credit})
                2'b10:   outstanding <= outstanding + OUT_CNT_W'(1);
                2'b01:   outstanding <= outstanding - OUT_CNT_W'(1);
                default: outstanding <= outstanding;
            endcase
        end
    end

    a_outstanding: assert property (
        @(posedge clk) disable iff (!rstn) outstanding <= OUT_CNT_W'(OUT_CREDITS)
    ) else $error("%0d beats outstanding", outstanding);

endmodule

/* logic/dw_line_ram.sv */
`timescale 1ns/1ps

module dw_line_ram
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
(
    input  logic               clk,
    input  logic               wr_en,
    input  logic [LINE_AW-1:0] wr_addr,
    input  pix_vec_t           wr_data,
    input  logic [LINE_AW-1:0] rd_addr,
    output pix_vec_t           rd_data
);

    pix_vec_t mem [MAX_LINE];   // one image line

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read-first: a same-address write is not seen until the next read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* logic/dw_row_buff.sv */
`timescale 1ns/1ps

module dw_row_buff
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  pix_vec_t           in_pix,
    input  logic               cfg_apply,
    input  logic [LINE_AW-1:0] cfg_line_len,
    output logic               col_valid,
    output row_col_t           col
);

    logic [LINE_AW-1:0] last_idx;       // line length minus one
    logic [LINE_AW-1:0] ptr;            // column position of the incoming beat
    logic [LINE_AW-1:0] ptr_q;          // position of the beat now on col
    pix_vec_t           pix_q;
    pix_vec_t           row1_data;
    pix_vec_t           row2_data;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_idx <= LINE_AW'(MAX_LINE - 1);
            ptr      <= '0;
        end else if (cfg_apply) begin
            last_idx <= cfg_line_len - LINE_AW'(1);   // 0 wraps to MAX_LINE
            ptr      <= '0;
        end else if (in_valid) begin
            ptr <= (ptr == last_idx) ? '0 : ptr + LINE_AW'(1);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_valid <= 1'b0;
        end else begin
            col_valid <= in_valid;
        end
    end

    // new pixel lines up with the registered memory reads
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pix_q <= in_pix;
            ptr_q <= ptr;
        end
    end

    dw_line_ram u_row1 (
        .clk     (clk),
        .wr_en   (in_valid),
        .wr_addr (ptr),
        .wr_data (in_pix),
        .rd_addr (ptr),
        .rd_data (row1_data)
    );

    // chained: row 2 takes what row 1 just gave out, at the same position
    dw_line_ram u_row2 (
        .clk     (clk),
        .wr_en   (col_valid),
        .wr_addr (ptr_q),
        .wr_data (row1_data),
        .rd_addr (ptr),
        .rd_data (row2_data)
    );

    assign col = {row2_data, row1_data, pix_q};

    a_ptr_in_line: assert property (
        @(posedge clk) disable iff (!rstn) ptr <= last_idx
    ) else $error("line pointer %0d beyond last index %0d", ptr, last_idx);

endmodule

/* logic/dw_types_pkg.sv */
package dw_types_pkg;
    import dw_cfg_pkg::*;

    typedef struct packed {
        logic signed [CH_NUM-1:0][DATA_W-1:0] px;   // px[c] is channel c
    } pix_vec_t;

    typedef struct packed {
        pix_vec_t top;      // two lines back
        pix_vec_t mid;      // one line back
        pix_vec_t bot;      // current line
    } row_col_t;

    typedef struct packed {
        row_col_t c0;       // oldest column
        row_col_t c1;
        row_col_t c2;       // newest column
        logic     win_ok;   // all nine taps from the current frame
    } win_t;

    // tap index is 3*row + col, row 0 = top, col 0 = c0
    typedef struct packed {
        logic        [CH_AW-1:0]  ch;
        logic        [TAP_AW-1:0] tap;
        logic signed [DATA_W-1:0] wt;
    } wt_wr_t;

    typedef struct packed {
        logic signed [CH_NUM-1:0][ACC_W-1:0] sum;   // sum[c] is channel c
        logic                                win_ok;
    } res_t;

endpackage

/* logic/dw_window.sv */
`timescale 1ns/1ps

module dw_window
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               cfg_apply,
    input  logic [LINE_AW-1:0] cfg_line_len,
    input  logic               col_valid,
    input  row_col_t           col,
    output logic               win_valid,
    output win_t               win
);

    logic [LINE_AW-1:0] last_idx;
    logic [LINE_AW-1:0] col_cnt;        // column of the incoming col
    logic [1:0]         row_cnt;        // saturates at 2
    logic               win_ok_q;
    row_col_t           c0_q;
    row_col_t           c1_q;
    row_col_t           c2_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_idx  <= LINE_AW'(MAX_LINE - 1);
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
            win_ok_q  <= 1'b0;
        end else begin
            win_valid <= col_valid;
            if (cfg_apply) begin
                last_idx <= cfg_line_len - LINE_AW'(1);
                col_cnt  <= '0;
                row_cnt  <= '0;
            end else if (col_valid) begin
                win_ok_q <= (col_cnt >= LINE_AW'(2)) && (row_cnt >= 2'd2);
                if (col_cnt == last_idx) begin
                    col_cnt <= '0;
                    if (row_cnt != 2'd2) begin
                        row_cnt <= row_cnt + 2'd1;
                    end
                end else begin
                    col_cnt <= col_cnt + LINE_AW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (col_valid) begin
            c0_q <= c1_q;                   // shift toward the oldest column
            c1_q <= c2_q;
            c2_q <= col;
        end
    end

    assign win = {c0_q, c1_q, c2_q, win_ok_q};

endmodule

/* sim.f */
logic/dw_cfg_pkg.sv
logic/dw_types_pkg.sv
logic/dw_line_ram.sv
logic/dw_row_buff.sv
logic/dw_window.sv
logic/dw_conv_pe.sv
logic/dw_conv_top.sv
verification/dw_conv_checker.sv
verification/tb_dw_conv.sv

/* verification/dw_conv_checker.sv */
`timescale 1ns/1ps

module dw_conv_checker
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  pix_vec_t           in_pix,
    input  logic               in_credit,
    input  logic               out_valid,
    input  res_t               out_res,
    input  logic               out_credit,
    input  logic               cfg_apply,
    input  logic [LINE_AW-1:0] cfg_line_len,
    input  logic               wt_we,
    input  wt_wr_t             wt_wr,
    output int                 err_cnt,
    output int                 beat_cnt,
    output int                 res_cnt
);

    pix_vec_t                 img [3][MAX_LINE];   // last three lines, by row mod 3
    logic signed [DATA_W-1:0] wt  [CH_NUM][TAP_NUM];
    res_t                     exp_q [$];
    int                       sent_q [$];          // cycle of each accepted beat
    int                       errs = 0;
    int                       beats = 0;
    int                       results = 0;
    int                       line_len;
    int                       row;
    int                       col;
    int                       cyc;
    int                       outstanding;
    logic                     out_credit_q;

    assign err_cnt  = errs;
    assign beat_cnt = beats;
    assign res_cnt  = results;

    task automatic mismatch(input string name, input int got, input int exp);
        $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        errs++;
    endtask

    task automatic fault(input string what);
        $display("Error at %0t: %s", $time, what);
        errs++;
    endtask

    // window whose newest pixel sits at row r, column c
    function automatic res_t predict(input int r, input int c);
        res_t e;
        int   acc;
        e        = '0;
        e.win_ok = (r >= 2) && (c >= 2);
        for (int ch = 0; ch < CH_NUM; ch++) begin
            acc = 0;
            if (e.win_ok) begin
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        acc += int'($signed(img[(r - 2 + i) % 3][c - 2 + j].px[ch]))
                             * int'(wt[ch][3 * i + j]);
                    end
                end
            end
            e.sum[ch] = ACC_W'(acc);
        end
        return e;
    endfunction

    always @(posedge clk) begin
        res_t e;
        int   t;
        if (!rstn) begin
            if (out_valid !== 1'b0)
                mismatch("out_valid", int'(out_valid), 0);
            if (in_credit !== 1'b0)
                mismatch("in_credit", int'(in_credit), 0);
            line_len     = MAX_LINE;
            row          = 0;
            col          = 0;
            cyc          = 0;
            outstanding  = 0;
            out_credit_q = 1'b0;
            exp_q.delete();
            sent_q.delete();
            for (int ch = 0; ch < CH_NUM; ch++) begin
                for (int tp = 0; tp < TAP_NUM; tp++) begin
                    wt[ch][tp] = '0;
                end
            end
        end else begin
            if (in_credit !== out_credit_q)              // credit echo, one cycle late
                mismatch("in_credit", int'(in_credit), int'(out_credit_q));
            out_credit_q = out_credit;
            outstanding += int'(in_valid) - int'(out_credit);
            if (outstanding > OUT_CREDITS)
                fault($sformatf("%0d results outstanding, limit is %0d", outstanding, OUT_CREDITS));
            if (outstanding < 0)
                fault("out_credit returned with no result outstanding");

            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fault("out_valid with no beat in flight");
                end else begin
                    e = exp_q.pop_front();
                    t = sent_q.pop_front();
                    results++;
                    if (cyc - t != PIPE_LAT)
                        mismatch("latency", cyc - t, PIPE_LAT);
                    if (out_res.win_ok !== e.win_ok) begin
                        mismatch("out_res.win_ok", int'(out_res.win_ok), int'(e.win_ok));
                    end else if (e.win_ok) begin
                        for (int ch = 0; ch < CH_NUM; ch++) begin
                            if (out_res.sum[ch] !== e.sum[ch])
                                mismatch($sformatf("out_res.sum[%0d]", ch),
                                         int'($signed(out_res.sum[ch])),
                                         int'($signed(e.sum[ch])));
                        end
                    end
                end
            end else if (sent_q.size() > 0 && cyc - sent_q[0] >= PIPE_LAT) begin
                fault("no result for an accepted beat, beat lost");
                void'(exp_q.pop_front());
                void'(sent_q.pop_front());
            end

            if (wt_we)
                wt[wt_wr.ch][wt_wr.tap] = wt_wr.wt;
            if (cfg_apply) begin
                line_len = (cfg_line_len == '0) ? MAX_LINE : int'(cfg_line_len);
                row      = 0;
                col      = 0;
            end
            if (in_valid) begin
                img[row % 3][col] = in_pix;
                exp_q.push_back(predict(row, col));
                sent_q.push_back(cyc);
                beats++;
                col++;
                if (col == line_len) begin
                    col = 0;
                    row++;
                end
            end
            cyc++;
        end
    end

endmodule

/* verification/tb_dw_conv.sv */
`timescale 1ns/1ps

module tb_dw_conv
    import dw_cfg_pkg::*;
    import dw_types_pkg::*;
();

    localparam int WAIT_MAX  = 1000;        // cycles before a wait gives up
    localparam int FRAME_MAX = 16 * 8;

    logic               clk = 1'b0;
    logic               rstn;
    logic               in_valid;
    pix_vec_t           in_pix;
    logic               in_credit;
    logic               out_valid;
    res_t               out_res;
    logic               out_credit;
    logic               cfg_apply;
    logic [LINE_AW-1:0] cfg_line_len;
    logic               wt_we;
    wt_wr_t             wt_wr;

    int       up_credits;                   // credits the upstream holds
    int       held;                         // results in the downstream buffer
    int       stall_left;
    int       stall_pct;                    // chance per cycle of a long stall
    int       tb_errs;
    int       err_cnt;
    int       beat_cnt;
    int       res_cnt;
    int       tests_run;
    int       tests_bad;
    int       errs_before;
    pix_vec_t frame [FRAME_MAX];

    always #5 clk = ~clk;

    dw_conv_top u_dw_conv_top (
        .clk (clk), .rstn (rstn),
        .in_valid (in_valid), .in_pix (in_pix), .in_credit (in_credit),
        .out_valid (out_valid), .out_res (out_res), .out_credit (out_credit),
        .cfg_apply (cfg_apply), .cfg_line_len (cfg_line_len),
        .wt_we (wt_we), .wt_wr (wt_wr)
    );

    dw_conv_checker u_checker (
        .clk (clk), .rstn (rstn),
        .in_valid (in_valid), .in_pix (in_pix), .in_credit (in_credit),
        .out_valid (out_valid), .out_res (out_res), .out_credit (out_credit),
        .cfg_apply (cfg_apply), .cfg_line_len (cfg_line_len),
        .wt_we (wt_we), .wt_wr (wt_wr),
        .err_cnt (err_cnt), .beat_cnt (beat_cnt), .res_cnt (res_cnt)
    );

    // one falling edge: clear pulses, count credits, run the downstream
    task automatic step();
        @(negedge clk);
        in_valid   = 1'b0;
        cfg_apply  = 1'b0;
        wt_we      = 1'b0;
        out_credit = 1'b0;
        if (in_credit)
            up_credits++;
        if (out_valid)
            held++;
        if (stall_left > 0) begin
            stall_left--;
        end else if (held > 0 && $urandom % 4 != 0) begin
            out_credit = 1'b1;                  // consume one result
            held--;
        end else if (int'($urandom % 100) < stall_pct) begin
            stall_left = 8 + int'($urandom % 40);
        end
    endtask

    task automatic send_beat(input pix_vec_t pix);
        int waited;
        waited = 0;
        step();
        if ($urandom % 5 == 0)
            step();                             // idle gap
        while (up_credits == 0 && waited < WAIT_MAX) begin
            step();
            waited++;
        end
        if (up_credits == 0) begin
            $display("Error at %0t: no input credit within %0d cycles", $time, WAIT_MAX);
            tb_errs++;
        end else begin
            in_valid = 1'b1;
            in_pix   = pix;
            up_credits--;
        end
    endtask

    // all credits home means every result came out and was consumed
    task automatic drain();
        int waited;
        waited = 0;
        step();
        while (up_credits != OUT_CREDITS && waited < WAIT_MAX) begin
            step();
            waited++;
        end
        if (up_credits != OUT_CREDITS) begin
            $display("Error at %0t: pipeline did not drain, %0d of %0d credits back",
                     $time, up_credits, OUT_CREDITS);
            tb_errs++;
        end
    endtask

    task automatic set_line(input int len);
        drain();
        step();
        cfg_apply    = 1'b1;
        cfg_line_len = LINE_AW'(len);
    endtask

    task automatic load_weights(input int ch);
        for (int t = 0; t < TAP_NUM; t++) begin
            step();
            wt_we     = 1'b1;
            wt_wr.ch  = CH_AW'(ch);
            wt_wr.tap = TAP_AW'(t);
            wt_wr.wt  = DATA_W'($urandom);
        end
    endtask

    task automatic make_frame(input int n);
        for (int i = 0; i < n; i++) begin
            for (int c = 0; c < CH_NUM; c++) begin
                frame[i].px[c] = DATA_W'($urandom);
            end
        end
    endtask

    task automatic send_frame(input int n);
        for (int i = 0; i < n; i++) begin
            send_beat(frame[i]);
        end
        drain();
    endtask

    task automatic finish_test(input string name);
        int errs_now;
        errs_now = err_cnt + tb_errs;
        tests_run++;
        if (errs_now != errs_before) begin
            tests_bad++;
            $display("[%0t] test %s: failed, %0d errors", $time, name, errs_now - errs_before);
        end else begin
            $display("[%0t] test %s: ok", $time, name);
        end
        errs_before = errs_now;
    endtask

    initial begin
        void'($urandom(32'h952e_c097));
        rstn         = 1'b0;
        in_valid     = 1'b0;
        in_pix       = '0;
        out_credit   = 1'b0;
        cfg_apply    = 1'b0;
        cfg_line_len = '0;
        wt_we        = 1'b0;
        wt_wr        = '0;
        up_credits   = OUT_CREDITS;
        held         = 0;
        stall_left   = 0;
        stall_pct    = 2;
        tb_errs      = 0;
        tests_run    = 0;
        tests_bad    = 0;
        errs_before  = 0;

        step();
        step();
        rstn = 1'b1;
        repeat (10) step();
        finish_test("reset state");

        set_line(16);
        for (int ch = 0; ch < CH_NUM; ch++) begin
            load_weights(ch);
        end
        make_frame(16 * 8);
        send_frame(16 * 8);
        finish_test("full frame");

        stall_pct = 0;
        set_line(16);
        make_frame(16 * 8);
        send_frame(16 * 8);
        finish_test("fixed latency");

        stall_pct = 25;                         // long downstream stalls
        set_line(16);
        make_frame(16 * 8);
        send_frame(16 * 8);
        finish_test("back-pressure");

        stall_pct = 2;
        set_line(10);
        make_frame(10 * 8);
        send_frame(10 * 8);
        finish_test("line length 10");

        set_line(10);
        load_weights(int'($urandom % CH_NUM));  // same frame again, one channel changed
        send_frame(10 * 8);
        finish_test("weight reload");

        $display("tests %0d, failed %0d, beats %0d, results %0d, errors %0d",
                 tests_run, tests_bad, beat_cnt, res_cnt, err_cnt + tb_errs);
        if (tests_bad == 0 && err_cnt + tb_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
